// ==== Bender.yml ====
package:
  name: cpu4

export_include_dirs:
  - hw

sources:
  - hw/cpu_pkg.sv
  - hw/cpu_control.sv
  - hw/program_counter.sv
  - hw/instr_fetch.sv
  - hw/reg_file.sv
  - hw/alu.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - tb/cpu_tb.sv

// ==== hw/alu.sv ====
`default_nettype none

`include "cpu_defines.svh"

module alu (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   en,
        input  cpu_pkg::instr_t        ir,
        input  logic [`CPU_DATA_W-1:0] rd_data,
        input  logic [`CPU_DATA_W-1:0] rs_data,
        output logic [`CPU_DATA_W-1:0] result,
        output logic                   ack
);
        import cpu_pkg::*;

        logic [`CPU_DATA_W-1:0] res_next;

        always_comb begin
                case (ir.alu.op)
                        OP_ADD: res_next = rd_data + rs_data;  // carry out dropped.
                        OP_SUB: res_next = rd_data - rs_data;
                        OP_LOGIC: begin
                                case (ir.alu.func)
                                        2'b00:   res_next = rd_data & rs_data;
                                        2'b01:   res_next = rd_data | rs_data;
                                        2'b10:   res_next = rd_data ^ rs_data;
                                        default: res_next = ~(rd_data | rs_data);
                                endcase
                        end
                        default: res_next = rd_data;  // ldr never enables the alu.
                endcase
        end

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        ack <= 1'b0;
                else
                        ack <= en;
        end

        // result is captured on the edge where ack rises.
        always_ff @(posedge clk) begin
                if (en && !ack)
                        result <= res_next;
        end

endmodule

`default_nettype wire

// ==== hw/cpu_control.sv ====
`default_nettype none

module cpu_control (
        input  logic             clk,
        input  logic             rst,
        input  logic             pc_ack,
        input  logic             ir_ack,
        input  logic             alu_ack,
        input  logic             wr_ack,
        input  cpu_pkg::opcode_t op,
        output cpu_pkg::ctrl_t   ctrl
);
        import cpu_pkg::*;

        state_t     state;
        state_t     state_next;
        logic [3:0] ena_vec;
        logic [3:0] ack_vec;

        // one unit enabled per state, write states carry the selects.
        function automatic ctrl_t decode(input state_t s);
                ctrl_t c;
                c = '0;
                case (s)
                        S_PC:       c.ena_pc = 1'b1;
                        S_FETCH:    c.ena_ir = 1'b1;
                        S_LDR: begin
                                c.ena_wr  = 1'b1;
                                c.sel_imm = 1'b1;
                        end
                        S_ARIT:     c.ena_alu = 1'b1;
                        S_WRITE_RD: c.ena_wr = 1'b1;
                        S_LOGIC:    c.ena_alu = 1'b1;
                        S_WRITE_R0: begin
                                c.ena_wr = 1'b1;
                                c.sel_r0 = 1'b1;
                        end
                        default:    c = '0;
                endcase
                return c;
        endfunction

        always_comb begin
                state_next = state;
                case (state)
                        S_PC: begin
                                if (pc_ack)
                                        state_next = S_FETCH;
                        end
                        S_FETCH: begin
                                if (ir_ack) begin
                                        case (op)
                                                OP_LDR:         state_next = S_LDR;
                                                OP_LOGIC:       state_next = S_LOGIC;
                                                OP_ADD, OP_SUB: state_next = S_ARIT;
                                        endcase
                                end
                        end
                        S_ARIT: begin
                                if (alu_ack)
                                        state_next = S_WRITE_RD;
                        end
                        S_LOGIC: begin
                                if (alu_ack)
                                        state_next = S_WRITE_R0;
                        end
                        S_LDR, S_WRITE_RD, S_WRITE_R0: begin
                                if (wr_ack)
                                        state_next = S_PC;
                        end
                        default: state_next = S_FETCH;
                endcase
        end

        // outputs decoded from the next state so they line up with state.
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        state <= S_FETCH;
                        ctrl  <= '0;
                end else begin
                        state <= state_next;
                        ctrl  <= decode(state_next);
                end
        end

        assign ena_vec = {ctrl.ena_pc, ctrl.ena_ir, ctrl.ena_wr, ctrl.ena_alu};
        assign ack_vec = {pc_ack, ir_ack, wr_ack, alu_ack};

        // a unit must have finished its last exchange before a new one starts.
        a_ena_rise_ack_low: assert property (@(posedge clk) disable iff (rst)
                ((ena_vec & ~$past(ena_vec)) & ack_vec) == 4'b0000);

        a_ena_onehot: assert property (@(posedge clk) disable iff (rst)
                $onehot0(ena_vec));

endmodule

`default_nettype wire

// ==== hw/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath width, all arithmetic wraps at 2**CPU_DATA_W.
`define CPU_DATA_W 4

// instruction memory address width.
`define CPU_PC_W 4

// architectural registers r0..r3.
`define CPU_NREG 4

`endif

// ==== hw/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

        typedef enum logic [1:0] {
                OP_LDR   = 2'b00,
                OP_LOGIC = 2'b01,
                OP_ADD   = 2'b10,
                OP_SUB   = 2'b11
        } opcode_t;

        typedef enum logic [2:0] {
                S_PC       = 3'd0,
                S_FETCH    = 3'd1,
                S_LDR      = 3'd2,
                S_ARIT     = 3'd3,
                S_WRITE_RD = 3'd4,
                S_LOGIC    = 3'd5,
                S_WRITE_R0 = 3'd6
        } state_t;

        typedef struct packed {
                opcode_t                      op;
                logic [$clog2(`CPU_NREG)-1:0] rd;
                logic [`CPU_DATA_W-1:0]       imm;
        } ldr_view_t;

        // func: 00 and, 01 or, 10 xor, 11 nor. ignored by add/sub.
        typedef struct packed {
                opcode_t                      op;
                logic [$clog2(`CPU_NREG)-1:0] rd;
                logic [$clog2(`CPU_NREG)-1:0] rs;
                logic [1:0]                   func;
        } alu_view_t;

        typedef union packed {
                ldr_view_t ldr;
                alu_view_t alu;
        } instr_t;

        typedef struct packed {
                logic ena_pc;
                logic ena_ir;
                logic ena_wr;
                logic ena_alu;
                logic sel_r0;   // write r0 instead of rd.
                logic sel_imm;  // write imm instead of alu result.
        } ctrl_t;

        typedef struct packed {
                logic                         valid;
                logic [$clog2(`CPU_NREG)-1:0] idx;
                logic [`CPU_DATA_W-1:0]       data;
        } wb_t;

endpackage

`default_nettype wire

// ==== hw/cpu_top.sv ====
`default_nettype none

`include "cpu_defines.svh"

module cpu_top (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 imem_ack,
        input  cpu_pkg::instr_t      imem_data,
        output logic                 imem_req,
        output logic [`CPU_PC_W-1:0] imem_addr,
        output cpu_pkg::wb_t         wb
);
        import cpu_pkg::*;

        ctrl_t                  ctrl;
        instr_t                 ir;
        logic [`CPU_PC_W-1:0]   pc;
        logic                   pc_ack;
        logic                   ir_ack;
        logic                   alu_ack;
        logic                   wr_ack;
        logic [`CPU_DATA_W-1:0] rd_data;
        logic [`CPU_DATA_W-1:0] rs_data;
        logic [`CPU_DATA_W-1:0] alu_result;

        cpu_control u_control (
                .clk     (clk),
                .rst     (rst),
                .pc_ack  (pc_ack),
                .ir_ack  (ir_ack),
                .alu_ack (alu_ack),
                .wr_ack  (wr_ack),
                .op      (ir.alu.op),
                .ctrl    (ctrl)
        );

        program_counter u_pc (
                .clk (clk),
                .rst (rst),
                .en  (ctrl.ena_pc),
                .ack (pc_ack),
                .pc  (pc)
        );

        instr_fetch u_fetch (
                .clk       (clk),
                .rst       (rst),
                .en        (ctrl.ena_ir),
                .pc        (pc),
                .imem_ack  (imem_ack),
                .imem_data (imem_data),
                .imem_req  (imem_req),
                .imem_addr (imem_addr),
                .ack       (ir_ack),
                .ir        (ir)
        );

        reg_file u_regs (
                .clk        (clk),
                .rst        (rst),
                .en         (ctrl.ena_wr),
                .sel_r0     (ctrl.sel_r0),
                .sel_imm    (ctrl.sel_imm),
                .ir         (ir),
                .alu_result (alu_result),
                .rd_data    (rd_data),
                .rs_data    (rs_data),
                .ack        (wr_ack),
                .wb         (wb)
        );

        alu u_alu (
                .clk     (clk),
                .rst     (rst),
                .en      (ctrl.ena_alu),
                .ir      (ir),
                .rd_data (rd_data),
                .rs_data (rs_data),
                .result  (alu_result),
                .ack     (alu_ack)
        );

endmodule

`default_nettype wire

// ==== hw/instr_fetch.sv ====
`default_nettype none

`include "cpu_defines.svh"

module instr_fetch (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 en,
        input  logic [`CPU_PC_W-1:0] pc,
        input  logic                 imem_ack,
        input  cpu_pkg::instr_t      imem_data,
        output logic                 imem_req,
        output logic [`CPU_PC_W-1:0] imem_addr,
        output logic                 ack,
        output cpu_pkg::instr_t      ir
);
        import cpu_pkg::*;

        logic drain;  // req dropped, waiting for imem_ack to fall.

        assign imem_addr = pc;  // pc is stable for the whole fetch.

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        imem_req <= 1'b0;
                        drain    <= 1'b0;
                        ack      <= 1'b0;
                end else begin
                        if (en && !imem_req && !drain && !ack)
                                imem_req <= 1'b1;
                        if (imem_req && imem_ack) begin
                                imem_req <= 1'b0;
                                drain    <= 1'b1;
                        end
                        if (drain && !imem_ack) begin
                                drain <= 1'b0;
                                ack   <= 1'b1;
                        end
                        if (ack && !en)
                                ack <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (imem_req && imem_ack)
                        ir <= imem_data;
        end

        // memory side of the handshake must not answer unasked.
        a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
                imem_ack |-> (imem_req || $past(imem_req)));

endmodule

`default_nettype wire

// ==== hw/program_counter.sv ====
`default_nettype none

`include "cpu_defines.svh"

module program_counter (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 en,
        output logic                 ack,
        output logic [`CPU_PC_W-1:0] pc
);

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        ack <= 1'b0;
                        pc  <= '0;
                end else begin
                        ack <= en;  // four-phase, ack follows en by a cycle.
                        if (en && !ack)
                                pc <= pc + 1'b1;  // wraps after the last address.
                end
        end

        a_en_rise_ack_low: assert property (@(posedge clk) disable iff (rst)
                $rose(en) |-> !ack);

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   en,
        input  logic                   sel_r0,
        input  logic                   sel_imm,
        input  cpu_pkg::instr_t        ir,
        input  logic [`CPU_DATA_W-1:0] alu_result,
        output logic [`CPU_DATA_W-1:0] rd_data,
        output logic [`CPU_DATA_W-1:0] rs_data,
        output logic                   ack,
        output cpu_pkg::wb_t           wb
);
        import cpu_pkg::*;

        logic [`CPU_DATA_W-1:0]       regs [`CPU_NREG];
        logic [$clog2(`CPU_NREG)-1:0] wr_addr;
        logic [`CPU_DATA_W-1:0]       wr_data;

        assign rd_data = regs[ir.alu.rd];
        assign rs_data = regs[ir.alu.rs];

        assign wr_addr = sel_r0 ? '0 : ir.alu.rd;  // logic results land in r0.
        assign wr_data = sel_imm ? ir.ldr.imm : alu_result;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        for (int i = 0; i < `CPU_NREG; i++)
                                regs[i] <= '0;
                        ack <= 1'b0;
                        wb  <= '0;
                end else begin
                        ack <= en;
                        if (en && !ack) begin
                                regs[wr_addr] <= wr_data;
                                wb <= '{valid: 1'b1, idx: wr_addr, data: wr_data};
                        end else begin
                                wb.valid <= 1'b0;  // one pulse per write.
                        end
                end
        end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_control.sv
hw/program_counter.sv
hw/instr_fetch.sv
hw/reg_file.sv
hw/alu.sv
hw/cpu_top.sv
tb/cpu_tb.sv

// ==== tb/cpu_tb.sv ====
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;
        timeunit 1ns;
        timeprecision 100ps;

        import cpu_pkg::*;

        logic                 clk = 1'b0;
        logic                 rst;
        logic                 imem_ack;
        instr_t               imem_data;
        logic                 imem_req;
        logic [`CPU_PC_W-1:0] imem_addr;
        wb_t                  wb;

        instr_t               prog [2**`CPU_PC_W];
        wb_t                  exp_q [$];
        logic [`CPU_PC_W-1:0] addr_q [$];
        logic [`CPU_PC_W-1:0] model_pc = '0;
        int                   n_instr = 0;
        int                   n_wb = 0;
        int                   n_fetch = 0;
        logic                 loaded = 1'b0;

        cpu_top DUT (
                .clk       (clk),
                .rst       (rst),
                .imem_ack  (imem_ack),
                .imem_data (imem_data),
                .imem_req  (imem_req),
                .imem_addr (imem_addr),
                .wb        (wb)
        );

        always #4 clk = ~clk;

        task automatic check_wb(input string name, input wb_t exp, input wb_t act);
                if (act !== exp) begin
                        $display("FAILED %s: expected %h, actual %h", name, exp, act);
                        $display("Result: FAILED");
                        $fatal(1, "write-back mismatch");
                end
        endtask

        task automatic check_fetch_addr(input string name, input logic [`CPU_PC_W-1:0] exp,
                                        input logic [`CPU_PC_W-1:0] act);
                if (act !== exp) begin
                        $display("FAILED %s: expected %h, actual %h", name, exp, act);
                        $display("Result: FAILED");
                        $fatal(1, "fetch address mismatch");
                end
        endtask

        // each line holds address, word, register written and value.
        task automatic load_trace();
                int                   fd;
                string                line;
                logic [`CPU_PC_W-1:0] a;
                logic [7:0]           w;
                logic [1:0]           r;
                logic [3:0]           v;
                wb_t                  e;
                for (int i = 0; i < 2**`CPU_PC_W; i++)
                        prog[i] = {4'h0, 4'(i)};  // ldr r0 of its own address.
                fd = $fopen("tb/cpu_trace.txt", "r");
                if (fd == 0) begin
                        $display("could not open the trace file tb/cpu_trace.txt");
                        $display("Result: FAILED");
                        $fatal(1, "no trace");
                end
                while (!$feof(fd)) begin
                        line = "";
                        if ($fgets(line, fd) == 0)
                                break;
                        if (line.len() < 7 || line.getc(0) == "#")
                                continue;
                        if ($sscanf(line, "%h %h %h %h", a, w, r, v) != 4) begin
                                $display("malformed trace line: %s", line);
                                $display("Result: FAILED");
                                $fatal(1, "bad trace");
                        end
                        prog[a] = w;
                        e.valid = 1'b1;
                        e.idx   = r;
                        e.data  = v;
                        exp_q.push_back(e);
                        addr_q.push_back(a);
                        n_instr++;
                end
                $fclose(fd);
                loaded = 1'b1;
        endtask

        // the memory answers each request after a random delay.
        initial begin : mem_responder
                int delay;
                void'($urandom(32'haee0_201d));
                forever begin
                        @(posedge clk);
                        #1;
                        if (imem_req && !imem_ack) begin
                                check_fetch_addr($sformatf("fetch %0d", n_fetch),
                                                 model_pc, imem_addr);
                                n_fetch++;
                                delay = $urandom % 4;
                                repeat (delay) begin
                                        @(posedge clk);
                                        #1;
                                end
                                imem_data = prog[imem_addr];
                                imem_ack  = 1'b1;
                                do begin
                                        @(posedge clk);
                                        #1;
                                end while (imem_req);
                                imem_ack = 1'b0;
                        end
                end
        end

        initial begin : wb_monitor
                wb_t                  exp;
                logic [`CPU_PC_W-1:0] a;
                forever begin
                        @(posedge clk);
                        #1;
                        if (wb.valid) begin
                                if (exp_q.size() == 0) begin
                                        $display("write-back seen after the last expected one");
                                        $display("Result: FAILED");
                                        $fatal(1, "extra write-back");
                                end
                                exp = exp_q.pop_front();
                                a   = addr_q.pop_front();
                                check_wb($sformatf("wb %0d at addr %0h", n_wb, a), exp, wb);
                                n_wb++;
                                model_pc = model_pc + 1'b1;  // wraps like the DUT pc.
                        end
                end
        end

        initial begin : watchdog
                wait (loaded);
                repeat ((n_instr + 1) * 40) @(posedge clk);
                $display("timeout: the program did not finish in time");
                $display("Result: FAILED");
                $fatal(1, "timeout");
        end

        initial begin : main
                rst       = 1'b1;
                imem_ack  = 1'b0;
                imem_data = '0;
                load_trace();
                repeat (5) @(posedge clk);
                #1 rst = 1'b0;
                // the extra fetch after the last write checks the pc wrap.
                wait (n_wb == n_instr && n_fetch == n_instr + 1);
                $display("Result: PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== tb/cpu_trace.txt ====
# addr instr reg val (hex), one line per instruction and the register write it makes.
# instr bits: [7:6] op, [5:4] rd, [3:0] imm, or rs in [3:2] and func in [1:0].
0 19 1 9
1 2c 2 c
2 98 1 5
3 37 3 7
4 dc 1 e
5 58 0 c
6 75 0 f
7 6e 0 b
8 7b 0 0
9 21 2 1
a bd 3 e
b b8 3 f
c ba 3 0
d c8 0 f
e 44 0 e
f eb 2 0
